//--- video_defines.svh
// Screen geometry, memory sizes and pipeline depth, included by the video RTL and its testbench
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// Horizontal raster, in pixel clocks
`define H_TOTAL      384
`define H_ACTIVE     256
`define HSYNC_START  304
`define HSYNC_END    336

// Vertical raster, in lines
`define V_TOTAL      264
`define V_START      16
`define V_END        240
`define VSYNC_START  248
`define VSYNC_END    251

// Counter value to RGB latency
`define PIPE_DEPTH   5

// Sprite list and sprite edge
`define N_SPRITES    16
`define SPR_SIZE     8

// Loader port and palette
`define WR_ADDR_W    14
`define WR_DATA_W    12
`define PAL_ENTRIES  512

`endif

//--- video_pkg.sv
// Shared types of the video core; modules import it for the write-port target and register view
package video_pkg;

	// Which memory or register file a loader write lands in
	typedef enum logic [2:0] {
		WR_REG     = 3'd0,
		WR_TILEMAP = 3'd1,
		WR_TILEPAT = 3'd2,
		WR_SPRLIST = 3'd3,
		WR_SPRPAT  = 3'd4,
		WR_PALETTE = 3'd5
	} wr_target_t;

	// One register byte, read either as a scroll value or as the flip flags
	typedef union packed {
		// Scroll offset in pixels
		logic [7:0] scroll;
		// Screen flip control
		struct packed {
			logic [5:0] spare;
			logic       vrev;
			logic       hrev;
		} flags;
	} video_reg_u;

endpackage

//--- raster_timing.sv
// Raster counters and sync/blank decode; instantiated once by video_top to pace both layers
`timescale 1ns/1ps
`include "video_defines.svh"

module raster_timing (
	input  logic                         pixel_clk,
	input  logic                         rst_i,
	output logic [$clog2(`H_TOTAL)-1:0]  hcount_o,
	output logic [$clog2(`V_TOTAL)-1:0]  vcount_o,
	output logic                         hblank_o,
	output logic                         vblank_o,
	output logic                         hsync_o,
	output logic                         vsync_o
);

	localparam int H_W = $clog2(`H_TOTAL);
	localparam int V_W = $clog2(`V_TOTAL);

	// ========================================
	// Counters
	// ========================================

	// End of line and end of frame
	logic h_last;
	logic v_last;

	assign h_last = (hcount_o == H_W'(`H_TOTAL - 1));
	assign v_last = (vcount_o == V_W'(`V_TOTAL - 1));

	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			hcount_o <= '0;
			vcount_o <= '0;
		end else begin
			if (h_last) begin
				hcount_o <= '0;
				// Line advances only on the horizontal wrap
				if (v_last) begin
					vcount_o <= '0;
				end else begin
					vcount_o <= vcount_o + 1'b1;
				end
			end else begin
				hcount_o <= hcount_o + 1'b1;
			end
		end
	end

	// ========================================
	// Window decode
	// ========================================

	// Raw windows, aligned with the counters; the mixer delays them
	assign hblank_o = (hcount_o >= H_W'(`H_ACTIVE));
	assign vblank_o = (vcount_o < V_W'(`V_START)) || (vcount_o >= V_W'(`V_END));
	// Active high syncs
	assign hsync_o  = (hcount_o >= H_W'(`HSYNC_START)) && (hcount_o < H_W'(`HSYNC_END));
	assign vsync_o  = (vcount_o >= V_W'(`VSYNC_START)) && (vcount_o < V_W'(`VSYNC_END));

endmodule

//--- tile_layer.sv
// Scrolling character layer; turns the raster position into a 6-bit tile pixel three clocks later
`timescale 1ns/1ps
`include "video_defines.svh"

module tile_layer (
	input  logic                         pixel_clk,
	input  logic                         rst_i,
	input  logic                         wr_en_i,
	input  video_pkg::wr_target_t        wr_target_i,
	input  logic [`WR_ADDR_W-1:0]        wr_addr_i,
	input  logic [`WR_DATA_W-1:0]        wr_data_i,
	input  logic [$clog2(`H_TOTAL)-1:0]  hcount_i,
	input  logic [$clog2(`V_TOTAL)-1:0]  vcount_i,
	// {colour[3:0], pixel[1:0]}
	output logic [5:0]                   tile_pix_o
);

	import video_pkg::*;

	// ========================================
	// Registers and memories
	// ========================================

	// Register file at addresses 0, 1 and 2
	video_reg_u scroll_x;
	video_reg_u scroll_y;
	video_reg_u ctrl;

	// 32x32 map entry: [11] vflip, [10] hflip, [9:6] colour, [5:0] code
	logic [11:0] tilemap [1024];
	// 64 tiles, 8 rows, 8 columns, 2 bits; address {code, row, col}
	logic [1:0]  tile_pat [4096];

	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			scroll_x <= '0;
			scroll_y <= '0;
			ctrl     <= '0;
		end else if (wr_en_i && (wr_target_i == WR_REG)) begin
			case (wr_addr_i[1:0])
				2'd0:    scroll_x <= wr_data_i[7:0];
				2'd1:    scroll_y <= wr_data_i[7:0];
				2'd2:    ctrl     <= wr_data_i[7:0];
				default: ;
			endcase
		end
	end

	// Loader writes into the map and pattern RAMs
	always_ff @(posedge pixel_clk) begin
		if (wr_en_i && (wr_target_i == WR_TILEMAP)) begin
			tilemap[wr_addr_i[9:0]] <= wr_data_i;
		end
		if (wr_en_i && (wr_target_i == WR_TILEPAT)) begin
			tile_pat[wr_addr_i[11:0]] <= wr_data_i[1:0];
		end
	end

	// ========================================
	// Pixel pipeline
	// ========================================

	// Screen position after flip, then scrolled position in the map
	logic [7:0] pos_x;
	logic [7:0] pos_y;
	logic [7:0] sum_x;
	logic [7:0] sum_y;

	// Mirror about the 256-pixel window
	assign pos_x = ctrl.flags.hrev ? (8'd255 - hcount_i[7:0]) : hcount_i[7:0];
	assign pos_y = ctrl.flags.vrev ? (8'd255 - vcount_i[7:0]) : vcount_i[7:0];
	assign sum_x = pos_x + scroll_x.scroll;
	assign sum_y = pos_y + scroll_y.scroll;

	// Stage 1 holds the map entry and the pixel position inside the tile
	logic [11:0] map_q;
	logic [2:0]  s1_col;
	logic [2:0]  s1_row;
	// Stage 2 holds the pattern bits and the tile colour
	logic [2:0]  pat_row;
	logic [2:0]  pat_col;
	logic [1:0]  pat_q;
	logic [3:0]  s2_colour;

	// Tile's own flips invert row and column
	assign pat_row = s1_row ^ {3{map_q[11]}};
	assign pat_col = s1_col ^ {3{map_q[10]}};

	always_ff @(posedge pixel_clk) begin
		map_q     <= tilemap[{sum_y[7:3], sum_x[7:3]}];
		s1_col    <= sum_x[2:0];
		s1_row    <= sum_y[2:0];
		pat_q     <= tile_pat[{map_q[5:0], pat_row, pat_col}];
		s2_colour <= map_q[9:6];
	end

	// Stage 3 output, three clocks after the counter value
	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			tile_pix_o <= '0;
		end else begin
			tile_pix_o <= {s2_colour, pat_q};
		end
	end

endmodule

//--- sprite_layer.sv
// Sprite layer with a per-line draw engine and double line buffers; read out three clocks late
`timescale 1ns/1ps
`include "video_defines.svh"

module sprite_layer (
	input  logic                         pixel_clk,
	input  logic                         rst_i,
	input  logic                         wr_en_i,
	input  video_pkg::wr_target_t        wr_target_i,
	input  logic [`WR_ADDR_W-1:0]        wr_addr_i,
	input  logic [`WR_DATA_W-1:0]        wr_data_i,
	input  logic [$clog2(`H_TOTAL)-1:0]  hcount_i,
	input  logic [$clog2(`V_TOTAL)-1:0]  vcount_i,
	// {colour[3:0], pixel[3:0]}
	output logic [7:0]                   spr_pix_o
);

	import video_pkg::*;

	localparam int IDX_W = $clog2(`N_SPRITES);
	localparam int COL_W = $clog2(`SPR_SIZE);
	localparam int H_W   = $clog2(`H_TOTAL);
	localparam int V_W   = $clog2(`V_TOTAL);

	// ========================================
	// Sprite list and pattern RAM
	// ========================================

	// Even word {colour, y}, odd word {pattern, x}
	logic [7:0] spr_y      [`N_SPRITES];
	logic [3:0] spr_colour [`N_SPRITES];
	logic [7:0] spr_x      [`N_SPRITES];
	logic [3:0] spr_pat    [`N_SPRITES];
	// 16 patterns, 8 rows, 8 columns, 4 bits; address {pattern, row, col}
	logic [3:0] pat_mem    [1024];

	always_ff @(posedge pixel_clk) begin
		if (wr_en_i && (wr_target_i == WR_SPRLIST)) begin
			if (!wr_addr_i[0]) begin
				spr_y[wr_addr_i[IDX_W:1]]      <= wr_data_i[7:0];
				spr_colour[wr_addr_i[IDX_W:1]] <= wr_data_i[11:8];
			end else begin
				spr_x[wr_addr_i[IDX_W:1]]      <= wr_data_i[7:0];
				spr_pat[wr_addr_i[IDX_W:1]]    <= wr_data_i[11:8];
			end
		end
		if (wr_en_i && (wr_target_i == WR_SPRPAT)) begin
			pat_mem[wr_addr_i[9:0]] <= wr_data_i[3:0];
		end
	end

	// ========================================
	// Draw engine
	// ========================================

	// One sprite column per clock, list order, starting at hcount 0
	logic             eng_busy;
	logic [IDX_W-1:0] eng_idx;
	logic [COL_W-1:0] eng_col;
	// Row inside the sprite for the next line
	logic [V_W-1:0]   dy;
	logic             hit;

	assign dy  = vcount_i + V_W'(1) - V_W'(spr_y[eng_idx]);
	assign hit = eng_busy && (dy < V_W'(`SPR_SIZE));

	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			eng_busy <= 1'b0;
			eng_idx  <= '0;
			eng_col  <= '0;
		end else if (hcount_i == '0) begin
			eng_busy <= 1'b1;
			eng_idx  <= '0;
			eng_col  <= '0;
		end else if (eng_busy) begin
			eng_col <= eng_col + 1'b1;
			if (eng_col == COL_W'(`SPR_SIZE - 1)) begin
				eng_idx <= eng_idx + 1'b1;
				// Last column of the last sprite ends the walk
				if (eng_idx == IDX_W'(`N_SPRITES - 1)) begin
					eng_busy <= 1'b0;
				end
			end
		end
	end

	// Pattern fetch stage; a_wx bit 8 marks a column past the right edge
	logic       a_valid;
	logic [8:0] a_wx;
	logic [3:0] a_colour;
	logic [3:0] pat_q;

	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			a_valid <= 1'b0;
		end else begin
			a_valid <= hit;
		end
	end

	always_ff @(posedge pixel_clk) begin
		pat_q    <= pat_mem[{spr_pat[eng_idx], dy[COL_W-1:0], eng_col}];
		a_wx     <= {1'b0, spr_x[eng_idx]} + 9'(eng_col);
		a_colour <= spr_colour[eng_idx];
	end

	// ========================================
	// Line buffers
	// ========================================

	logic [7:0] line_buf [2][256];
	// Buffer being drawn; the other one is on screen
	logic       back_sel;
	// Read-out stages
	logic       rd_en;
	logic [7:0] rd_x;
	logic [7:0] rd_q;
	logic       draw_ok;

	// Opaque pixel, on screen, and the slot still empty so lower index wins
	assign draw_ok = a_valid && !a_wx[8] && (pat_q != 4'd0)
		&& (line_buf[back_sel][a_wx[7:0]][3:0] == 4'd0);

	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			for (int i = 0; i < 256; i++) begin
				line_buf[0][i] <= '0;
				line_buf[1][i] <= '0;
			end
			back_sel <= 1'b0;
			rd_q     <= '0;
		end else begin
			// Swap so the freshly drawn buffer is on screen from hcount 0
			if (hcount_i == H_W'(`H_TOTAL - 1)) begin
				back_sel <= ~back_sel;
			end
			if (draw_ok) begin
				line_buf[back_sel][a_wx[7:0]] <= {a_colour, pat_q};
			end
			if (rd_en) begin
				rd_q <= line_buf[!back_sel][rd_x];
				// Clear behind the read, ready for the next draw
				line_buf[!back_sel][rd_x] <= '0;
			end else begin
				rd_q <= '0;
			end
		end
	end

	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			rd_en     <= 1'b0;
			rd_x      <= '0;
			spr_pix_o <= '0;
		end else begin
			rd_en     <= (hcount_i < H_W'(`H_ACTIVE));
			rd_x      <= hcount_i[7:0];
			spr_pix_o <= rd_q;
		end
	end

endmodule

//--- pixel_mixer.sv
// Priority select, palette lookup and sync alignment; drives every video output of video_top
`timescale 1ns/1ps
`include "video_defines.svh"

module pixel_mixer (
	input  logic                   pixel_clk,
	input  logic                   rst_i,
	input  logic                   wr_en_i,
	input  video_pkg::wr_target_t  wr_target_i,
	input  logic [`WR_ADDR_W-1:0]  wr_addr_i,
	input  logic [`WR_DATA_W-1:0]  wr_data_i,
	input  logic [5:0]             tile_pix_i,
	input  logic [7:0]             spr_pix_i,
	input  logic                   hsync_i,
	input  logic                   vsync_i,
	input  logic                   hblank_i,
	input  logic                   vblank_i,
	output logic [11:0]            rgb_o,
	output logic                   hsync_o,
	output logic                   vsync_o,
	output logic                   hblank_o,
	output logic                   vblank_o
);

	import video_pkg::*;

	localparam int PAL_W = $clog2(`PAL_ENTRIES);

	// ========================================
	// Palette
	// ========================================

	logic [11:0]      palette [`PAL_ENTRIES];
	logic [PAL_W-1:0] pal_addr;
	logic [11:0]      pal_q;

	// Opaque sprite pixel wins, else the tile pixel in the lower half
	assign pal_addr = (spr_pix_i[3:0] != 4'd0)
		? {1'b1, spr_pix_i[7:4], spr_pix_i[3:0]}
		: {1'b0, tile_pix_i[5:2], 2'b00, tile_pix_i[1:0]};

	always_ff @(posedge pixel_clk) begin
		if (wr_en_i && (wr_target_i == WR_PALETTE)) begin
			palette[wr_addr_i[PAL_W-1:0]] <= wr_data_i;
		end
		pal_q <= palette[pal_addr];
	end

	// ========================================
	// Sync delay and blank forcing
	// ========================================

	// Each stage is {hsync, vsync, hblank, vblank}
	logic [`PIPE_DEPTH-1:0][3:0] sync_d;

	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			sync_d <= '0;
			rgb_o  <= '0;
		end else begin
			sync_d <= {sync_d[`PIPE_DEPTH-2:0], {hsync_i, vsync_i, hblank_i, vblank_i}};
			// Blank one stage early so it lines up with the palette data
			rgb_o  <= (sync_d[`PIPE_DEPTH-2][1:0] != 2'b00) ? 12'h000 : pal_q;
		end
	end

	assign hsync_o  = sync_d[`PIPE_DEPTH-1][3];
	assign vsync_o  = sync_d[`PIPE_DEPTH-1][2];
	assign hblank_o = sync_d[`PIPE_DEPTH-1][1];
	assign vblank_o = sync_d[`PIPE_DEPTH-1][0];

endmodule

//--- video_top.sv
// Video core top level; the testbench instantiates it and loads it through the write port
`timescale 1ns/1ps
`include "video_defines.svh"

module video_top (
	input  logic                   pixel_clk,
	input  logic                   rst_i,
	input  logic                   wr_en_i,
	input  video_pkg::wr_target_t  wr_target_i,
	input  logic [`WR_ADDR_W-1:0]  wr_addr_i,
	input  logic [`WR_DATA_W-1:0]  wr_data_i,
	output logic [11:0]            rgb_o,
	output logic                   hsync_o,
	output logic                   vsync_o,
	output logic                   hblank_o,
	output logic                   vblank_o
);

	// ========================================
	// Raster to layers and mixer
	// ========================================

	logic [$clog2(`H_TOTAL)-1:0] hcount;
	logic [$clog2(`V_TOTAL)-1:0] vcount;
	// Raw windows, undelayed
	logic hblank_raw;
	logic vblank_raw;
	logic hsync_raw;
	logic vsync_raw;
	// Layer outputs, both three clocks behind the counters
	logic [5:0] tile_pix;
	logic [7:0] spr_pix;

	raster_timing raster_timing_i (
		.pixel_clk (pixel_clk),
		.rst_i     (rst_i),
		.hcount_o  (hcount),
		.vcount_o  (vcount),
		.hblank_o  (hblank_raw),
		.vblank_o  (vblank_raw),
		.hsync_o   (hsync_raw),
		.vsync_o   (vsync_raw)
	);

	tile_layer tile_layer_i (
		.pixel_clk   (pixel_clk),
		.rst_i       (rst_i),
		.wr_en_i     (wr_en_i),
		.wr_target_i (wr_target_i),
		.wr_addr_i   (wr_addr_i),
		.wr_data_i   (wr_data_i),
		.hcount_i    (hcount),
		.vcount_i    (vcount),
		.tile_pix_o  (tile_pix)
	);

	sprite_layer sprite_layer_i (
		.pixel_clk   (pixel_clk),
		.rst_i       (rst_i),
		.wr_en_i     (wr_en_i),
		.wr_target_i (wr_target_i),
		.wr_addr_i   (wr_addr_i),
		.wr_data_i   (wr_data_i),
		.hcount_i    (hcount),
		.vcount_i    (vcount),
		.spr_pix_o   (spr_pix)
	);

	// Final two stages and all outputs
	pixel_mixer pixel_mixer_i (
		.pixel_clk   (pixel_clk),
		.rst_i       (rst_i),
		.wr_en_i     (wr_en_i),
		.wr_target_i (wr_target_i),
		.wr_addr_i   (wr_addr_i),
		.wr_data_i   (wr_data_i),
		.tile_pix_i  (tile_pix),
		.spr_pix_i   (spr_pix),
		.hsync_i     (hsync_raw),
		.vsync_i     (vsync_raw),
		.hblank_i    (hblank_raw),
		.vblank_i    (vblank_raw),
		.rgb_o       (rgb_o),
		.hsync_o     (hsync_o),
		.vsync_o     (vsync_o),
		.hblank_o    (hblank_o),
		.vblank_o    (vblank_o)
	);

endmodule

//--- video_assertions.sv
// Checker bound into video_top; follows the screen position from the blanks and asserts output rules
`timescale 1ns/1ps
`include "video_defines.svh"

module video_assertions (
	input logic                   pixel_clk,
	input logic                   rst_i,
	input logic                   wr_en_i,
	input video_pkg::wr_target_t  wr_target_i,
	input logic [`WR_ADDR_W-1:0]  wr_addr_i,
	input logic [`WR_DATA_W-1:0]  wr_data_i,
	input logic [11:0]            rgb_o,
	input logic                   hsync_o,
	input logic                   vsync_o,
	input logic                   hblank_o,
	input logic                   vblank_o
);

	import video_pkg::*;

	// Failed assertion count that the testbench reads
	int unsigned err_count = 0;

	// ========================================
	// Scene shadow from the write port
	// ========================================

	logic [7:0] scroll_x_sh;
	logic       hrev_sh;
	logic [7:0] spr_y_sh   [`N_SPRITES];
	logic [7:0] spr_x_sh   [`N_SPRITES];
	logic [3:0] spr_col_sh [`N_SPRITES];
	logic [3:0] spr_sel_sh [`N_SPRITES];
	logic [3:0] spr_pat_sh [1024];
	// Set once the last palette entry lands and the scene is complete
	logic       loaded;

	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			scroll_x_sh <= '0;
			hrev_sh     <= 1'b0;
			loaded      <= 1'b0;
		end else if (wr_en_i) begin
			if (wr_target_i == WR_REG && wr_addr_i[1:0] == 2'd0) begin
				scroll_x_sh <= wr_data_i[7:0];
			end
			if (wr_target_i == WR_REG && wr_addr_i[1:0] == 2'd2) begin
				hrev_sh <= wr_data_i[0];
			end
			if (wr_target_i == WR_PALETTE && wr_addr_i == `WR_ADDR_W'(`PAL_ENTRIES - 1)) begin
				loaded <= 1'b1;
			end
		end
	end

	always_ff @(posedge pixel_clk) begin
		if (wr_en_i && wr_target_i == WR_SPRLIST) begin
			if (!wr_addr_i[0]) begin
				spr_y_sh[wr_addr_i[4:1]]   <= wr_data_i[7:0];
				spr_col_sh[wr_addr_i[4:1]] <= wr_data_i[11:8];
			end else begin
				spr_x_sh[wr_addr_i[4:1]]   <= wr_data_i[7:0];
				spr_sel_sh[wr_addr_i[4:1]] <= wr_data_i[11:8];
			end
		end
		if (wr_en_i && wr_target_i == WR_SPRPAT) begin
			spr_pat_sh[wr_addr_i[9:0]] <= wr_data_i[3:0];
		end
	end

	// Expected colour from the layer and palette rules with palette entry i holding i
	function automatic logic [11:0] expect_rgb(input logic [8:0] col, input logic [7:0] row);
		int         vc;
		int         dx;
		int         dy;
		logic [3:0] p;
		logic [7:0] xm;
		logic [7:0] sum;
		vc = int'(row) + `V_START;
		// Lowest list index with an opaque pixel wins
		for (int i = 0; i < `N_SPRITES; i++) begin
			dy = vc - int'(spr_y_sh[i]);
			dx = int'(col) - int'(spr_x_sh[i]);
			if (dy >= 0 && dy < `SPR_SIZE && dx >= 0 && dx < `SPR_SIZE) begin
				p = spr_pat_sh[{spr_sel_sh[i], 3'(dy), 3'(dx)}];
				if (p != 4'd0) begin
					return {3'b001, spr_col_sh[i], p};
				end
			end
		end
		xm  = hrev_sh ? (8'd255 - col[7:0]) : col[7:0];
		sum = xm + scroll_x_sh;
		// Tile colour 3 with the scrolled column mod 4 as pixel
		return {4'h0, 4'h3, 2'b00, sum[1:0]};
	endfunction

	// ========================================
	// Screen position and period counters
	// ========================================

	logic        rst_d;
	logic        hblank_d;
	logic        vblank_d;
	logic        hsync_d;
	logic        vsync_d;
	logic [8:0]  col_q;
	logic [7:0]  row_q;
	logic        seen_line;
	logic        check_on;
	logic        h_seen;
	logic        v_seen;
	int unsigned h_gap;
	int unsigned v_gap;
	logic [11:0] exp_rgb;

	always_comb begin
		exp_rgb = expect_rgb(col_q, row_q);
	end

	always_ff @(posedge pixel_clk) begin
		rst_d <= rst_i;
	end

	always_ff @(posedge pixel_clk) begin
		if (rst_i) begin
			hblank_d  <= 1'b0;
			vblank_d  <= 1'b0;
			hsync_d   <= 1'b0;
			vsync_d   <= 1'b0;
			col_q     <= '0;
			row_q     <= '0;
			seen_line <= 1'b0;
			check_on  <= 1'b0;
			h_seen    <= 1'b0;
			v_seen    <= 1'b0;
			h_gap     <= 0;
			v_gap     <= 0;
		end else begin
			hblank_d <= hblank_o;
			vblank_d <= vblank_o;
			hsync_d  <= hsync_o;
			vsync_d  <= vsync_o;
			col_q    <= hblank_o ? '0 : col_q + 1'b1;
			if (vblank_o) begin
				row_q <= '0;
			end else if (hblank_o && !hblank_d) begin
				row_q <= row_q + 1'b1;
			end
			if (!hblank_o && hblank_d) begin
				seen_line <= 1'b1;
			end
			// Pixel checks start with the first frame after a full load
			if (!vblank_o && vblank_d) begin
				check_on <= loaded;
			end
			if (hsync_o && !hsync_d) begin
				h_gap  <= 1;
				h_seen <= 1'b1;
			end else begin
				h_gap <= h_gap + 1;
			end
			if (vsync_o && !vsync_d) begin
				v_gap  <= 1;
				v_seen <= 1'b1;
			end else begin
				v_gap <= v_gap + 1;
			end
		end
	end

	// ========================================
	// Output rules
	// ========================================

	reset_outputs: assert property (@(posedge pixel_clk)
		rst_d |-> (rgb_o == 12'h000 && !hsync_o && !vsync_o && !hblank_o && !vblank_o))
	else begin
		err_count++;
		$error("sync, blank or rgb output active right after a reset clock");
	end

	hsync_period: assert property (@(posedge pixel_clk) disable iff (rst_i)
		(hsync_o && !hsync_d && h_seen) |-> (h_gap == `H_TOTAL))
	else begin
		err_count++;
		$error("hsync_o period was %0d clocks instead of %0d", $sampled(h_gap), `H_TOTAL);
	end

	vsync_period: assert property (@(posedge pixel_clk) disable iff (rst_i)
		(vsync_o && !vsync_d && v_seen) |-> (v_gap == `H_TOTAL * `V_TOTAL))
	else begin
		err_count++;
		$error("vsync_o period was %0d clocks", $sampled(v_gap));
	end

	active_width: assert property (@(posedge pixel_clk) disable iff (rst_i)
		(hblank_o && !hblank_d && seen_line) |-> (col_q == 9'(`H_ACTIVE)))
	else begin
		err_count++;
		$error("line had %0d clocks with hblank_o low", $sampled(col_q));
	end

	blank_black: assert property (@(posedge pixel_clk) disable iff (rst_i)
		(hblank_o || vblank_o) |-> (rgb_o == 12'h000))
	else begin
		err_count++;
		$error("[FAIL] rgb_o got 0x%03h expected 0x000 in blank", $sampled(rgb_o));
	end

	pixel_value: assert property (@(posedge pixel_clk) disable iff (rst_i)
		(check_on && !hblank_o && !vblank_o) |-> (rgb_o == exp_rgb))
	else begin
		err_count++;
		$error("[FAIL] rgb_o got 0x%03h expected 0x%03h at col %0d row %0d",
			$sampled(rgb_o), $sampled(exp_rgb), $sampled(col_q), $sampled(row_q));
	end

endmodule

bind video_top video_assertions video_assertions_i (.*);

//--- tb_clock_gen.sv
// Testbench pixel clock and power-on reset source for the video_top testbench
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int CLK_PERIOD_NS = 40,
	parameter int RESET_CYCLES  = 10
) (
	output logic pixel_clk,
	output logic rst_o
);

	// Free running pixel clock
	initial begin
		pixel_clk = 1'b0;
		forever begin
			#(CLK_PERIOD_NS / 2) pixel_clk = ~pixel_clk;
		end
	end

	// Reset held for a fixed number of clocks, released on a rising edge
	initial begin
		rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge pixel_clk);
		rst_o <= 1'b0;
	end

endmodule

//--- video_tb.sv
// Testbench top for video_top; loads scenes in vblank and reports the bound assertion results
`timescale 1ns/1ps
`include "video_defines.svh"

module video_tb;

	import video_pkg::*;

	localparam int CLK_NS        = 40;
	localparam int FRAME_CLKS    = `H_TOTAL * `V_TOTAL;
	// Frames used by the test sequence below, plus slack
	localparam int FRAMES_NEEDED = 12;
	localparam int FRAME_MARGIN  = 4;
	localparam longint WATCHDOG_NS =
		longint'(FRAMES_NEEDED + FRAME_MARGIN) * FRAME_CLKS * CLK_NS;

	logic                  pixel_clk;
	logic                  rst_i;
	logic                  wr_en_i;
	wr_target_t            wr_target_i;
	logic [`WR_ADDR_W-1:0] wr_addr_i;
	logic [`WR_DATA_W-1:0] wr_data_i;
	logic [11:0]           rgb_o;
	logic                  hsync_o;
	logic                  vsync_o;
	logic                  hblank_o;
	logic                  vblank_o;

	int          seed;
	int          tests_run;
	int          tests_failed;
	int unsigned err_before;
	int          scroll;
	int          spr_x;
	int          spr_y;

	tb_clock_gen #(.CLK_PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) tb_clock_gen_i (
		.pixel_clk (pixel_clk),
		.rst_o     (rst_i)
	);

	video_top video_top_i (
		.pixel_clk   (pixel_clk),
		.rst_i       (rst_i),
		.wr_en_i     (wr_en_i),
		.wr_target_i (wr_target_i),
		.wr_addr_i   (wr_addr_i),
		.wr_data_i   (wr_data_i),
		.rgb_o       (rgb_o),
		.hsync_o     (hsync_o),
		.vsync_o     (vsync_o),
		.hblank_o    (hblank_o),
		.vblank_o    (vblank_o)
	);

	// ========================================
	// Write port helpers
	// ========================================

	// Writes start at the vsync edge well inside vblank
	task automatic open_window();
		@(posedge vsync_o);
	endtask

	task automatic write_word(input wr_target_t target, input int addr, input int data);
		@(posedge pixel_clk);
		wr_en_i     <= 1'b1;
		wr_target_i <= target;
		wr_addr_i   <= `WR_ADDR_W'(addr);
		wr_data_i   <= `WR_DATA_W'(data);
	endtask

	task automatic close_window();
		@(posedge pixel_clk);
		wr_en_i <= 1'b0;
	endtask

	task automatic wait_frames(input int n);
		repeat (n) @(posedge vsync_o);
	endtask

	// The base scene of about 6700 writes fits in one vblank
	task automatic load_scene();
		open_window();
		for (int i = 0; i < 3; i++) begin
			write_word(WR_REG, i, 0);
		end
		// Sprites parked at line 0 inside vblank
		for (int i = 0; i < 2 * `N_SPRITES; i++) begin
			write_word(WR_SPRLIST, i, 0);
		end
		for (int i = 0; i < 1024; i++) begin
			write_word(WR_SPRPAT, i, 0);
		end
		// Colour 3 with no flips and varied codes
		for (int i = 0; i < 1024; i++) begin
			write_word(WR_TILEMAP, i, (3 << 6) | (i % 64));
		end
		// Each pixel is its column mod 4
		for (int i = 0; i < 4096; i++) begin
			write_word(WR_TILEPAT, i, i & 3);
		end
		// Identity palette goes last so the checker sees a complete scene
		for (int i = 0; i < `PAL_ENTRIES; i++) begin
			write_word(WR_PALETTE, i, i);
		end
		close_window();
	endtask

	task automatic finish_test(input string name);
		int unsigned errs;
		errs = video_top_i.video_assertions_i.err_count - err_before;
		tests_run++;
		if (errs == 0) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d assertion failures", tests_run, name, errs);
		end
		err_before = video_top_i.video_assertions_i.err_count;
	endtask

	// ========================================
	// Sequence
	// ========================================

	initial begin
		seed         = 87;
		tests_run    = 0;
		tests_failed = 0;
		err_before   = 0;
		wr_en_i      = 1'b0;
		wr_target_i  = WR_REG;
		wr_addr_i    = '0;
		wr_data_i    = '0;
		@(negedge rst_i);

		load_scene();
		wait_frames(2);
		finish_test("reset, sync and blank timing");

		wait_frames(1);
		finish_test("rgb black during blank");

		// Odd random scroll moves the pixel phase, then the mirrored screen
		scroll = ($unsigned($random(seed)) % 128) * 2 + 1;
		open_window();
		write_word(WR_REG, 0, scroll);
		close_window();
		wait_frames(1);
		open_window();
		write_word(WR_REG, 2, 1);
		close_window();
		wait_frames(1);
		finish_test("tile scroll and hrev");

		// Solid sprite 0 with pattern 1 and colour 2
		spr_x = 16 + $unsigned($random(seed)) % 200;
		spr_y = 40 + $unsigned($random(seed)) % 150;
		open_window();
		write_word(WR_REG, 2, 0);
		for (int k = 0; k < 64; k++) begin
			write_word(WR_SPRPAT, 64 + k, 7);
		end
		write_word(WR_SPRLIST, 0, (2 << 8) | spr_y);
		write_word(WR_SPRLIST, 1, (1 << 8) | spr_x);
		close_window();
		wait_frames(1);
		finish_test("solid sprite over tiles");

		// Sprite 1 with clear even columns overlaps sprite 0
		open_window();
		for (int k = 0; k < 64; k++) begin
			write_word(WR_SPRPAT, 128 + k, (k & 1) ? 5 : 0);
		end
		write_word(WR_SPRLIST, 2, (4 << 8) | (spr_y + 3));
		write_word(WR_SPRLIST, 3, (2 << 8) | (spr_x + 4));
		close_window();
		wait_frames(1);
		finish_test("transparent columns and overlap");

		$display("tests run %0d, passed %0d, failed %0d, assertion errors %0d",
			tests_run, tests_run - tests_failed, tests_failed,
			video_top_i.video_assertions_i.err_count);
		if (tests_failed == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog sized from the frame count of the sequence
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog timeout: expected frames did not arrive in time");
		$display(">>> FAIL");
		$finish;
	end

endmodule

//--- files.f
+incdir+.
video_pkg.sv
raster_timing.sv
tile_layer.sv
sprite_layer.sv
pixel_mixer.sv
video_top.sv
video_assertions.sv
tb_clock_gen.sv
video_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= video_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
